// ==== dram_write_path.f ====
hdl/dwc_pkg.sv
hdl/or_crossbar_column.sv
hdl/dram_addr_decoder.sv
hdl/dram_write_collector.sv
hdl/dram_write_path.sv
verif/tb_dram_write_path.sv

// ==== hdl/dram_addr_decoder.sv ====
/*
 * Splits a strided vector store into one burst per touched cache block.
 * Each burst carries the block address, the lane-to-word routing table and
 * a last flag. Command and bursts use rdy/ack handshakes.
 */

`timescale 1ns/1ps

module dram_addr_decoder (
	input  logic                i_clk,
	input  logic                i_rst,
	input  logic                i_cmd_rdy,
	output logic                o_cmd_ack,
	input  dwc_pkg::store_cmd_t i_cmd,
	output logic                o_dec_rdy,
	input  logic                i_dec_ack,
	output dwc_pkg::addr_t      o_dec_addr,
	output dwc_pkg::route_t     o_dec_route,
	output logic                o_dec_islast
);
	import dwc_pkg::*;

	// ====================
	// State
	// ====================

	dec_state_t state;
	// Latched command fields
	addr_t base_r;
	addr_t stride_r;
	// Lanes not yet sent in a burst
	lane_mask_t pend;

	// ====================
	// Lane decode
	// ====================

	addr_t [VSIZE-1:0] lane_addr;
	lane_mask_t lowest;
	addr_t lead_addr;
	lane_mask_t match;

	// Lane v address is base + v*stride modulo 2**GBW
	always_comb begin
		addr_t acc;
		acc = base_r;
		for (int v = 0; v < VSIZE; v++) begin
			lane_addr[v] = acc;
			acc = acc + stride_r;
		end
	end

	// One-hot of the lowest pending lane
	assign lowest = pend & (~pend + 1'b1);

	// Address of the lowest pending lane or zero when nothing pends
	always_comb begin
		lead_addr = '0;
		for (int v = 0; v < VSIZE; v++) begin
			lead_addr = lead_addr | (lane_addr[v] & {GBW{lowest[v]}});
		end
	end

	// Pending lanes in the same block as the lead lane
	always_comb begin
		for (int v = 0; v < VSIZE; v++) begin
			match[v] = pend[v] && (lane_addr[v][GBW-1:CBW] == lead_addr[GBW-1:CBW]);
		end
	end

	// Route each matching lane to its word in the block
	always_comb begin
		for (int c = 0; c < CSIZE; c++) begin
			for (int v = 0; v < VSIZE; v++) begin
				o_dec_route[c][v] = match[v] && (lane_addr[v][CBW-1:0] == CBW'(c));
			end
		end
	end

	assign o_dec_addr = {lead_addr[GBW-1:CBW], {CBW{1'b0}}};
	// Last when this burst drains the pending set
	assign o_dec_islast = ~|(pend & ~match);
	assign o_dec_rdy = (state == EMIT);
	assign o_cmd_ack = (state == IDLE) && i_cmd_rdy;

	// ====================
	// Sequential
	// ====================

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= IDLE;
			pend <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (i_cmd_rdy) begin
						state <= EMIT;
						pend <= i_cmd.lane_en;
					end
				end
				EMIT: begin
					// Back-pressure holds the current burst
					if (i_dec_ack) begin
						pend <= pend & ~match;
						if (o_dec_islast) begin
							state <= IDLE;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Base and stride only change on a command ack
	always_ff @(posedge i_clk) begin
		if (o_cmd_ack) begin
			base_r <= i_cmd.base;
			stride_r <= i_cmd.stride;
		end
	end

endmodule

// ==== hdl/dram_write_collector.sv ====
/*
 * Joins routed bursts with ALU vector data and builds the DRAM block write.
 * ALU data is held until the last burst of a command is taken.
 * The result sits in a one-entry output register.
 * Bursts with an empty mask are dropped there without a handshake.
 */

`timescale 1ns/1ps

module dram_write_collector (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_dec_rdy,
	output logic               o_dec_ack,
	input  dwc_pkg::addr_t     i_dec_addr,
	input  dwc_pkg::route_t    i_dec_route,
	input  logic               i_dec_islast,
	input  logic               i_alu_rdy,
	output logic               o_alu_ack,
	input  dwc_pkg::vec_data_t i_alu_dat,
	output logic               o_dramw_rdy,
	input  logic               i_dramw_ack,
	output dwc_pkg::dram_wr_t  o_dramw
);
	import dwc_pkg::*;

	// ====================
	// Internal
	// ====================

	// Joined source side
	logic src_rdy;
	logic src_ack;
	// Output register occupancy
	logic full;
	logic out_free;
	// Crossbar result
	blk_data_t  blk_w;
	word_mask_t mask_w;

	// ====================
	// Crossbar
	// ====================

	// Column c builds word c from route entry c
	generate
		for (genvar c = 0; c < CSIZE; c++) begin : g_col
			or_crossbar_column u_colx (
				.i_lanes (i_alu_dat),
				.i_sel   (i_dec_route[c]),
				.o_word  (blk_w[c]),
				.o_hit   (mask_w[c])
			);
		end
	endgenerate

	// ====================
	// Handshake
	// ====================

	// Both burst and ALU data must be present
	assign src_rdy = i_dec_rdy && i_alu_rdy;
	// Room when empty or draining this cycle
	assign out_free = !full || i_dramw_ack;
	assign src_ack = src_rdy && out_free;

	assign o_dec_ack = src_ack;
	// ALU vector is consumed with the last burst only
	assign o_alu_ack = src_ack && i_dec_islast;

	// Only non-empty entries are offered
	assign o_dramw_rdy = full;

	// ====================
	// Output register
	// ====================

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			full <= 1'b0;
			o_dramw <= '0;
		end else if (src_ack) begin
			o_dramw.addr <= i_dec_addr;
			o_dramw.data <= blk_w;
			o_dramw.mask <= mask_w;
			// Empty mask never raises rdy
			full <= |mask_w;
		end else if (i_dramw_ack) begin
			full <= 1'b0;
		end
	end

endmodule

// ==== hdl/dram_write_path.sv ====
/*
 * Top of the vector store write-back path.
 * Commands go into the address decoder, whose bursts feed the write
 * collector together with the ALU vector. Block writes leave toward DRAM.
 */

`timescale 1ns/1ps

module dram_write_path (
	input  logic                i_clk,
	input  logic                i_rst,
	// Command stream
	input  logic                i_cmd_rdy,
	output logic                o_cmd_ack,
	input  dwc_pkg::store_cmd_t i_cmd,
	// ALU data stream
	input  logic                i_alu_rdy,
	output logic                o_alu_ack,
	input  dwc_pkg::vec_data_t  i_alu_dat,
	// Write stream
	output logic                o_dramw_rdy,
	input  logic                i_dramw_ack,
	output dwc_pkg::dram_wr_t   o_dramw
);
	import dwc_pkg::*;

	// ====================
	// Burst stream
	// ====================

	logic   dec_rdy;
	logic   dec_ack;
	addr_t  dec_addr;
	route_t dec_route;
	logic   dec_islast;

	dram_addr_decoder u_dec (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_cmd_rdy    (i_cmd_rdy),
		.o_cmd_ack    (o_cmd_ack),
		.i_cmd        (i_cmd),
		.o_dec_rdy    (dec_rdy),
		.i_dec_ack    (dec_ack),
		.o_dec_addr   (dec_addr),
		.o_dec_route  (dec_route),
		.o_dec_islast (dec_islast)
	);

	dram_write_collector u_col (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_dec_rdy    (dec_rdy),
		.o_dec_ack    (dec_ack),
		.i_dec_addr   (dec_addr),
		.i_dec_route  (dec_route),
		.i_dec_islast (dec_islast),
		.i_alu_rdy    (i_alu_rdy),
		.o_alu_ack    (o_alu_ack),
		.i_alu_dat    (i_alu_dat),
		.o_dramw_rdy  (o_dramw_rdy),
		.i_dramw_ack  (i_dramw_ack),
		.o_dramw      (o_dramw)
	);

endmodule

// ==== hdl/dwc_pkg.sv ====
/*
 * Shared widths, sizes and types for the DRAM write-back path.
 * Modules import it inside their bodies and use scoped names in port lists.
 * Vectors are packed with element 0 in the low bits.
 */

package dwc_pkg;

	// ====================
	// Sizes
	// ====================

	// Global word address and data word widths
	localparam int GBW = 16;
	localparam int DBW = 16;
	// Vector lanes and words per cache block
	localparam int VSIZE = 8;
	localparam int CSIZE = 8;
	// Word offset bits inside a block, log2 of CSIZE
	localparam int CBW = 3;

	// ====================
	// Types
	// ====================

	typedef logic [GBW-1:0] addr_t;
	typedef logic [DBW-1:0] data_t;
	typedef logic [VSIZE-1:0] lane_mask_t;
	typedef logic [CSIZE-1:0] word_mask_t;

	// Lane 0 / word 0 sit in the low bits
	typedef logic [VSIZE-1:0][DBW-1:0] vec_data_t;
	typedef logic [CSIZE-1:0][DBW-1:0] blk_data_t;

	// Entry c holds the lanes that write block word c
	typedef logic [CSIZE-1:0][VSIZE-1:0] route_t;

	// Strided vector store
	typedef struct packed {
		addr_t      base;
		addr_t      stride;
		lane_mask_t lane_en;
	} store_cmd_t;

	// One block write to a block-aligned addr
	typedef struct packed {
		addr_t      addr;
		blk_data_t  data;
		word_mask_t mask;
	} dram_wr_t;

	typedef enum logic {IDLE, EMIT} dec_state_t;

endpackage

// ==== hdl/or_crossbar_column.sv ====
/*
 * One column of the write crossbar. Produces a single cache word by ORing
 * every vector lane selected for it, plus a hit bit for the word mask.
 * Colliding lanes merge by OR.
 */

`timescale 1ns/1ps

module or_crossbar_column (
	input  dwc_pkg::vec_data_t  i_lanes,
	input  dwc_pkg::lane_mask_t i_sel,
	output dwc_pkg::data_t      o_word,
	output logic                o_hit
);
	import dwc_pkg::*;

	// ====================
	// OR reduction
	// ====================

	always_comb begin
		o_word = '0;
		// Unselected lanes contribute zero
		for (int v = 0; v < VSIZE; v++) begin
			if (i_sel[v]) begin
				o_word = o_word | i_lanes[v];
			end
		end
	end

	// Word is written when any lane lands on it
	assign o_hit = |i_sel;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile the DRAM write path testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_dram_write_path \
	-f dram_write_path.f \
	-o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "All tests passed!"; then
	exit 0
fi
echo "Simulation did not pass"
exit 1

// ==== verif/tb_dram_write_path.sv ====
/*
 * Testbench for the DRAM write-back path.
 * Random strided stores and ALU vectors go in through rdy/ack streams.
 * A reference model expands each store into its expected block writes,
 * which are checked by assertions as the DRAM sink takes them.
 */

`timescale 1ns/1ps

module tb_dram_write_path;
	import dwc_pkg::*;

	localparam int TOTAL_CMDS = 40;

	logic       i_clk = 1'b0;
	logic       i_rst = 1'b1;
	logic       i_cmd_rdy = 1'b0;
	logic       o_cmd_ack;
	store_cmd_t i_cmd = '0;
	logic       i_alu_rdy = 1'b0;
	logic       o_alu_ack;
	vec_data_t  i_alu_dat = '0;
	logic       o_dramw_rdy;
	logic       i_dramw_ack = 1'b0;
	dram_wr_t   o_dramw;

	// Stimulus queues and expected writes
	store_cmd_t cmd_q[$];
	vec_data_t  alu_q[$];
	dram_wr_t   exp_q[$];
	dram_wr_t   exp_w;
	logic [31:0] rng;
	logic [31:0] ack_rng = 32'd97;
	logic bp_mode = 1'b0;
	// Error counts by checker
	int rst_errs = 0;
	int hold_errs = 0;
	int cmp_errs = 0;
	int main_errs = 0;
	int writes_seen = 0;
	int writes_exp = 0;
	int errs_mark = 0;
	int tests_pass = 0;
	int tests_fail = 0;

	always #5 i_clk = ~i_clk;

	dram_write_path u_dram_write_path (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_cmd_rdy   (i_cmd_rdy),
		.o_cmd_ack   (o_cmd_ack),
		.i_cmd       (i_cmd),
		.i_alu_rdy   (i_alu_rdy),
		.o_alu_ack   (o_alu_ack),
		.i_alu_dat   (i_alu_dat),
		.o_dramw_rdy (o_dramw_rdy),
		.i_dramw_ack (i_dramw_ack),
		.o_dramw     (o_dramw)
	);

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] rand_next();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic int total_errors();
		return rst_errs + hold_errs + cmp_errs + main_errs;
	endfunction

	// Reference model that emits one write per touched block in lowest-pending-lane order
	function automatic void expand_store(input store_cmd_t cmd, input vec_data_t vec);
		lane_mask_t pend;
		addr_t      a;
		addr_t      lead_a;
		dram_wr_t   w;
		int         lead;
		pend = cmd.lane_en;
		while (pend != '0) begin
			lead = -1;
			for (int v = 0; v < VSIZE; v++) begin
				if (pend[v] && lead < 0) begin
					lead = v;
				end
			end
			lead_a = cmd.base + addr_t'(lead) * cmd.stride;
			w = '0;
			w.addr = {lead_a[GBW-1:CBW], {CBW{1'b0}}};
			for (int v = 0; v < VSIZE; v++) begin
				a = cmd.base + addr_t'(v) * cmd.stride;
				if (pend[v] && a[GBW-1:CBW] == lead_a[GBW-1:CBW]) begin
					// Colliding lanes merge by OR
					w.data[a[CBW-1:0]] = w.data[a[CBW-1:0]] | vec[v];
					w.mask[a[CBW-1:0]] = 1'b1;
					pend[v] = 1'b0;
				end
			end
			exp_q.push_back(w);
			writes_exp++;
		end
	endfunction

	task automatic push_store(input addr_t base, input addr_t stride, input lane_mask_t en);
		store_cmd_t cmd;
		vec_data_t  vec;
		cmd.base = base;
		cmd.stride = stride;
		cmd.lane_en = en;
		for (int v = 0; v < VSIZE; v++) begin
			vec[v] = data_t'(rand_next());
		end
		cmd_q.push_back(cmd);
		alu_q.push_back(vec);
		expand_store(cmd, vec);
	endtask

	// Wait until every stream is empty and the last write is taken
	task automatic drain();
		while (cmd_q.size() != 0 || alu_q.size() != 0 || exp_q.size() != 0
				|| i_cmd_rdy || i_alu_rdy) begin
			@(posedge i_clk);
		end
		repeat (4) @(posedge i_clk);
	endtask

	task automatic end_test(input string name);
		if (total_errors() == errs_mark) begin
			tests_pass++;
			$display("Test %s: PASS", name);
		end else begin
			tests_fail++;
			$display("Test %s: FAIL with %0d errors", name, total_errors() - errs_mark);
		end
		errs_mark = total_errors();
	endtask

	// ====================
	// Stream drivers
	// ====================

	always @(posedge i_clk) begin
		if (i_rst) begin
			i_cmd_rdy <= 1'b0;
		end else if (!i_cmd_rdy || o_cmd_ack) begin
			if (cmd_q.size() != 0) begin
				i_cmd <= cmd_q.pop_front();
				i_cmd_rdy <= 1'b1;
			end else begin
				i_cmd_rdy <= 1'b0;
			end
		end
	end

	always @(posedge i_clk) begin
		if (i_rst) begin
			i_alu_rdy <= 1'b0;
		end else if (!i_alu_rdy || o_alu_ack) begin
			if (alu_q.size() != 0) begin
				i_alu_dat <= alu_q.pop_front();
				i_alu_rdy <= 1'b1;
			end else begin
				i_alu_rdy <= 1'b0;
			end
		end
	end

	// DRAM sink with one-cycle ack pulses that are rare in back-pressure mode
	always @(posedge i_clk) begin
		ack_rng = xorshift(ack_rng);
		if (i_rst) begin
			i_dramw_ack <= 1'b0;
		end else if (o_dramw_rdy && !i_dramw_ack) begin
			i_dramw_ack <= bp_mode ? (ack_rng[2:0] == 3'd0) : (ack_rng[1:0] != 2'd0);
		end else begin
			i_dramw_ack <= 1'b0;
		end
	end

	// ====================
	// Checks
	// ====================

	reset_idle: assert property (@(posedge i_clk)
		i_rst |-> (!o_dramw_rdy && !o_cmd_ack && !o_alu_ack))
		else begin
			rst_errs++;
			$display("Outputs active during reset at %0t", $time);
		end

	// Withheld ack keeps the write offered and unchanged
	write_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		(o_dramw_rdy && !i_dramw_ack) |=> (o_dramw_rdy && $stable(o_dramw)))
		else begin
			hold_errs++;
			$display("MISMATCH at %0t: write dropped or changed while ack withheld", $time);
		end

	// Mid-cycle sample of each completed write handshake
	always @(negedge i_clk) begin
		if (!i_rst && o_dramw_rdy && i_dramw_ack) begin
			writes_seen++;
			if (exp_q.size() == 0) begin
				cmp_errs++;
				$display("Unexpected extra DRAM write at %0t to address %h", $time, o_dramw.addr);
			end else begin
				exp_w = exp_q.pop_front();
				assert (o_dramw == exp_w) else begin
					cmp_errs++;
					$display("MISMATCH at %0t: got addr %h data %h mask %h, want addr %h data %h mask %h",
						$time, o_dramw.addr, o_dramw.data, o_dramw.mask,
						exp_w.addr, exp_w.data, exp_w.mask);
				end
			end
		end
	end

	// Watchdog sized from the command count
	initial begin
		repeat (200 * TOTAL_CMDS) @(posedge i_clk);
		$display("Timeout after %0d cycles, the DUT stopped making progress", 200 * TOTAL_CMDS);
		$display("Test failures found");
		$finish;
	end

	// ====================
	// Test sequence
	// ====================

	initial begin
		rng = 32'd97;
		repeat (5) @(posedge i_clk);
		i_rst <= 1'b0;
		@(negedge i_clk);
		assert (!o_dramw_rdy && !o_cmd_ack && !o_alu_ack && o_dramw == '0) else begin
			main_errs++;
			$display("Outputs not idle right after reset at %0t", $time);
		end
		end_test("reset");

		// Whole aligned block where word c gets lane c
		for (int i = 0; i < 2; i++) begin
			push_store({addr_t'(rand_next())} & ~addr_t'(CSIZE - 1), 16'd1, 8'hff);
		end
		drain();
		end_test("aligned");

		// Small strides give collisions and large ones spread over blocks
		for (int i = 0; i < 12; i++) begin
			if (i % 2 == 0) begin
				push_store(addr_t'(rand_next()), addr_t'(rand_next() % 12), 8'hff);
			end else begin
				push_store(addr_t'(rand_next()), addr_t'(rand_next()), 8'hff);
			end
		end
		drain();
		end_test("strided");

		for (int i = 0; i < 12; i++) begin
			push_store(addr_t'(rand_next()), addr_t'(rand_next() % 6), lane_mask_t'(rand_next()));
		end
		drain();
		end_test("partial_enable");

		// Empty stores still consume one ALU vector each
		push_store(addr_t'(rand_next()), 16'd1, 8'h00);
		push_store(addr_t'(rand_next()), 16'd3, 8'hff);
		push_store(addr_t'(rand_next()), 16'd2, 8'h00);
		push_store(addr_t'(rand_next()), 16'd1, 8'h5a);
		drain();
		end_test("lanes_disabled");

		bp_mode = 1'b1;
		for (int i = 0; i < 10; i++) begin
			push_store(addr_t'(rand_next()), addr_t'(rand_next() % 10), lane_mask_t'(rand_next()));
		end
		drain();
		bp_mode = 1'b0;
		if (writes_seen != writes_exp || exp_q.size() != 0) begin
			main_errs++;
			$display("Write count wrong, %0d seen and %0d expected", writes_seen, writes_exp);
		end
		end_test("back_pressure");

		$display("Summary: %0d tests passed, %0d failed, %0d of %0d writes checked",
			tests_pass, tests_fail, writes_seen, writes_exp);
		if (total_errors() == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
